// ==== sources.f ====
hw/rv_pkg.sv
hw/pc_unit.sv
hw/control_decoder.sv
hw/imm_gen.sv
hw/regfile.sv
hw/alu.sv
hw/rv32_core.sv
test/tb_rv32_core.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it, failing unless the pass line appears
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f sources.f --top-module tb_rv32_core -o sim_tb &&
./obj_dir/sim_tb | tee /dev/stderr | grep -qx "NO ERRORS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== test/tb_rv32_core.sv ====
// Directed testbench for rv32_core with instruction and data memory models, run through sources.f
`timescale 1ns/1ps

module tb_rv32_core;
    import rv_pkg::*;

    localparam word_t       MARK_ADDR = 32'd252;
    localparam logic [11:0] MARK      = 12'h5a5;
    localparam word_t       NOP       = 32'h0000_0013; // ADDI x0, x0, 0
    localparam int          TIMEOUT   = 6 * 200;

    logic  clk;
    logic  reset;
    word_t imem_addr;
    word_t imem_data;
    word_t dmem_addr;
    word_t dmem_wdata;
    logic  dmem_we;
    word_t dmem_rdata;

    word_t imem [64];
    word_t dmem [64];
    word_t prog [$];
    word_t exp_addr [$];
    word_t exp_data [$];
    word_t log_addr [$];
    word_t log_data [$];
    int    marker_count = 0;
    int    cycles = 0;
    int    errors = 0;
    int    checks = 0;

    rv32_core #(.RESET_PC(DEFAULT_RESET_PC)) rv32_core_inst (
        .clk        (clk),
        .reset      (reset),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_we    (dmem_we),
        .dmem_rdata (dmem_rdata)
    );

    assign imem_data  = imem[imem_addr[7:2]];
    assign dmem_rdata = dmem[dmem_addr[7:2]];

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Data memory, refilled while reset is high, and store log
    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 64; i++) begin
                dmem[i] <= word_t'(i) * 32'h9e37_79b1;
            end
        end else if (dmem_we) begin
            dmem[dmem_addr[7:2]] <= dmem_wdata;
            if (dmem_addr == MARK_ADDR) begin
                marker_count <= marker_count + 1;
            end else begin
                log_addr.push_back(dmem_addr);
                log_data.push_back(dmem_wdata);
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT) begin
            $display("timeout after %0d cycles while waiting for a test to finish", cycles);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic word_t r_type(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, OP};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                     reg_idx_t rd, opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t s_type(logic [11:0] imm, reg_idx_t rs2, reg_idx_t rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], STORE};
    endfunction

    function automatic word_t b_type(logic [12:0] off, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], BRANCH};
    endfunction

    function automatic word_t u_type(logic [19:0] u, reg_idx_t rd, opcode_e op);
        return {u, rd, op};
    endfunction

    function automatic word_t j_type(logic [20:0] off, reg_idx_t rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, JAL};
    endfunction

    // Reference results from the RV32I rules
    function automatic word_t expected_alu(logic [2:0] f3, logic alt, word_t x, word_t y);
        case (f3)
            3'd0:    return alt ? x - y : x + y;
            3'd1:    return x << y[4:0];
            3'd2:    return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'd3:    return (x < y) ? 32'd1 : 32'd0;
            3'd4:    return x ^ y;
            3'd5:    return alt ? word_t'($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'd6:    return x | y;
            default: return x & y;
        endcase
    endfunction

    function automatic logic expected_taken(logic [2:0] f3, word_t x, word_t y);
        case (f3)
            3'b000:  return x == y;
            3'b001:  return x != y;
            3'b100:  return $signed(x) < $signed(y);
            3'b101:  return $signed(x) >= $signed(y);
            3'b110:  return x < y;
            default: return x >= y;
        endcase
    endfunction

    task automatic check_word(string name, word_t expected, word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s data expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_addr(string name, word_t expected, word_t actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s address expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_flag(string name, logic expected, logic actual);
        checks++;
        if (expected !== actual) begin
            errors++;
            $display("[FAIL] %s flag expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic load_imm(reg_idx_t rd, word_t value);
        word_t rounded;
        rounded = value + 32'h800; // Offsets the sign of the ADDI part
        prog.push_back(u_type(rounded[31:12], rd, LUI));
        prog.push_back(i_type(value[11:0], rd, 3'b000, rd, OP_IMM));
    endtask

    task automatic store_expect(reg_idx_t rs, int slot, word_t value);
        prog.push_back(s_type(12'(slot * 4), rs, 5'd0));
        exp_addr.push_back(word_t'(slot * 4));
        exp_data.push_back(value);
    endtask

    // Loads the program, resets the core and compares the stores seen up to the marker
    task automatic run_program(string name);
        int base_mark;
        int base_log;
        int n;
        prog.push_back(i_type(MARK, 5'd0, 3'b000, 5'd31, OP_IMM));
        prog.push_back(s_type(MARK_ADDR[11:0], 5'd31, 5'd0));
        prog.push_back(j_type(21'd0, 5'd0)); // Park on a self loop
        @(posedge clk);
        #1 reset = 1'b1;
        for (int i = 0; i < 64; i++) begin
            imem[i] = (i < prog.size()) ? prog[i] : NOP;
        end
        base_mark = marker_count;
        base_log  = log_addr.size();
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;
        while (marker_count == base_mark) @(posedge clk);
        #1;
        n = log_addr.size() - base_log;
        if (n != exp_addr.size()) begin
            errors++;
            $display("%s: expected %0d stores but saw %0d", name, exp_addr.size(), n);
        end
        for (int i = 0; i < n && i < exp_addr.size(); i++) begin
            check_addr(name, exp_addr[i], log_addr[base_log + i]);
            check_word(name, exp_data[i], log_data[base_log + i]);
        end
        prog.delete();
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic report_test(string name, int errors_before);
        if (errors == errors_before) begin
            $display("%s: passed", name);
        end else begin
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    task automatic alu_ops();
        int          e0;
        int          slot;
        word_t       a;
        word_t       b;
        logic [11:0] imm;
        logic [2:0]  f3;
        logic        alt;
        e0   = errors;
        slot = 0;
        a    = $urandom;
        b    = $urandom;
        load_imm(5'd1, a);
        load_imm(5'd2, b);
        for (int k = 0; k < 10; k++) begin
            f3  = (k < 8) ? 3'(k) : ((k == 8) ? 3'd0 : 3'd5);
            alt = (k >= 8);
            prog.push_back(r_type(alt ? 7'b0100000 : 7'b0, 5'd2, 5'd1, f3, 5'd3));
            store_expect(5'd3, slot, expected_alu(f3, alt, a, b));
            slot++;
        end
        for (int k = 0; k < 9; k++) begin
            f3  = (k < 8) ? 3'(k) : 3'd5;
            alt = (k == 8);
            imm = 12'($urandom);
            if (f3 == 3'd1 || f3 == 3'd5) begin
                imm = {alt ? 7'b0100000 : 7'b0, imm[4:0]};
            end
            prog.push_back(i_type(imm, 5'd1, f3, 5'd4, OP_IMM));
            store_expect(5'd4, slot, expected_alu(f3, alt, a, {{20{imm[11]}}, imm}));
            slot++;
        end
        run_program("alu");
        report_test("alu", e0);
    endtask

    task automatic load_store_round_trip();
        int    e0;
        word_t val;
        word_t addr;
        e0 = errors;
        prog.push_back(i_type(12'd64, 5'd0, 3'b000, 5'd6, OP_IMM)); // Base in x6
        for (int k = 0; k < 4; k++) begin
            val  = $urandom;
            addr = 32'd64 + word_t'(8 + 4 * k);
            load_imm(5'd5, val);
            prog.push_back(s_type(12'(8 + 4 * k), 5'd5, 5'd6));
            prog.push_back(i_type(12'(8 + 4 * k), 5'd6, 3'b010, 5'd7, LOAD));
            prog.push_back(s_type(12'(72 + 4 * k), 5'd7, 5'd6));
            exp_addr.push_back(addr);
            exp_data.push_back(val);
            exp_addr.push_back(addr + 32'd64);
            exp_data.push_back(val);
        end
        run_program("load_store");
        report_test("load_store", e0);
    endtask

    task automatic branch_decisions();
        int         e0;
        word_t      xs [4];
        word_t      ys [4];
        logic [2:0] f3s [6];
        e0  = errors;
        xs  = '{32'd5, 32'd5, 32'h8000_0000, 32'd1};
        ys  = '{32'd5, 32'd7, 32'd1, 32'h8000_0000};
        f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        for (int p = 0; p < 4; p++) begin
            load_imm(5'd1, xs[p]);
            load_imm(5'd2, ys[p]);
            for (int k = 0; k < 6; k++) begin
                prog.push_back(b_type(13'd12, 5'd2, 5'd1, f3s[k]));
                prog.push_back(i_type(12'd1, 5'd0, 3'b000, 5'd3, OP_IMM)); // Fall-through
                prog.push_back(j_type(21'd8, 5'd0));
                prog.push_back(i_type(12'd2, 5'd0, 3'b000, 5'd3, OP_IMM)); // Target
                store_expect(5'd3, k, expected_taken(f3s[k], xs[p], ys[p]) ? 32'd2 : 32'd1);
            end
            run_program("branches");
        end
        report_test("branches", e0);
    endtask

    task automatic jump_links();
        int e0;
        int j;
        e0 = errors;
        j  = prog.size();
        prog.push_back(j_type(21'd12, 5'd1));
        prog.push_back(i_type(12'd1, 5'd0, 3'b000, 5'd9, OP_IMM)); // Skipped
        prog.push_back(i_type(12'd1, 5'd0, 3'b000, 5'd9, OP_IMM));
        store_expect(5'd1, 0, word_t'(j * 4 + 4));
        j = prog.size() + 1;
        prog.push_back(i_type(12'((j + 3) * 4 + 1), 5'd0, 3'b000, 5'd5, OP_IMM)); // Odd base
        prog.push_back(i_type(12'd0, 5'd5, 3'b000, 5'd6, JALR));
        prog.push_back(i_type(12'd1, 5'd0, 3'b000, 5'd9, OP_IMM));
        prog.push_back(i_type(12'd1, 5'd0, 3'b000, 5'd9, OP_IMM));
        store_expect(5'd6, 1, word_t'(j * 4 + 4));
        store_expect(5'd9, 2, 32'd0);
        run_program("jumps");
        report_test("jumps", e0);
    endtask

    task automatic upper_and_x0();
        int          e0;
        int          p;
        logic [19:0] u;
        e0 = errors;
        u  = 20'($urandom);
        prog.push_back(u_type(u, 5'd10, LUI));
        store_expect(5'd10, 0, {u, 12'b0});
        u = 20'($urandom);
        p = prog.size();
        prog.push_back(u_type(u, 5'd11, AUIPC));
        store_expect(5'd11, 1, word_t'(p * 4) + {u, 12'b0});
        prog.push_back(i_type(12'd123, 5'd0, 3'b000, 5'd0, OP_IMM));
        store_expect(5'd0, 2, 32'd0);
        run_program("upper_x0");
        report_test("upper_x0", e0);
    endtask

    task automatic reset_sequence();
        int e0;
        e0 = errors;
        @(posedge clk);
        #1 reset = 1'b1;
        imem[0] = s_type(12'd0, 5'd0, 5'd0); // A store held back by reset
        for (int i = 1; i < 64; i++) begin
            imem[i] = NOP;
        end
        repeat (3) begin
            #2;
            check_flag("reset", 1'b0, dmem_we);
            check_addr("reset", 32'd0, imem_addr);
            @(posedge clk);
        end
        #1 reset = 1'b0;
        #1 check_addr("reset", 32'd0, imem_addr);
        for (int k = 1; k <= 5; k++) begin
            @(posedge clk);
            #2 check_addr("reset", word_t'(4 * k), imem_addr);
        end
        report_test("reset", e0);
    endtask

    initial begin
        int seed_val;
        reset    = 1'b1;
        seed_val = $urandom(32'hc85b);
        for (int i = 0; i < 64; i++) begin
            imem[i] = NOP;
        end
        alu_ops();
        load_store_round_trip();
        branch_decisions();
        jump_links();
        upper_and_x0();
        reset_sequence();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== hw/rv32_core.sv ====
// Single-cycle RV32I core top level with external instruction and data memory ports
`timescale 1ns/1ps

module rv32_core #(
    parameter rv_pkg::word_t RESET_PC = rv_pkg::DEFAULT_RESET_PC
) (
    input  logic          clk,
    input  logic          reset,
    output rv_pkg::word_t imem_addr,
    input  rv_pkg::word_t imem_data,
    output rv_pkg::word_t dmem_addr,
    output rv_pkg::word_t dmem_wdata,
    output logic          dmem_we,
    input  rv_pkg::word_t dmem_rdata
);
    import rv_pkg::*;

    alu_op_e  alu_op;
    cmp_op_e  cmp_op;
    wb_sel_e  wb_sel;
    pc_sel_e  pc_sel;
    logic     alu_src_imm;
    logic     alu_src_pc;
    logic     is_branch;
    logic     reg_we;
    logic     mem_we;
    reg_idx_t rs1;
    reg_idx_t rs2;
    reg_idx_t rd;
    word_t    imm;
    word_t    rs1_data;
    word_t    rs2_data;
    word_t    op_a;
    word_t    op_b;
    word_t    result;
    logic     branch_taken;
    word_t    pc;
    word_t    pc_plus4;
    word_t    wb_data;

    control_decoder control_decoder_inst (
        .instr       (imem_data),
        .alu_op      (alu_op),
        .cmp_op      (cmp_op),
        .alu_src_imm (alu_src_imm),
        .alu_src_pc  (alu_src_pc),
        .wb_sel      (wb_sel),
        .pc_sel      (pc_sel),
        .is_branch   (is_branch),
        .reg_we      (reg_we),
        .mem_we      (mem_we),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd)
    );

    imm_gen imm_gen_inst (
        .instr (imem_data),
        .imm   (imm)
    );

    regfile regfile_inst (
        .clk      (clk),
        .reset    (reset),
        .we       (reg_we),
        .rs1      (rs1),
        .rs2      (rs2),
        .rd       (rd),
        .wdata    (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    assign op_a = alu_src_pc ? pc : rs1_data; // PC for AUIPC
    assign op_b = alu_src_imm ? imm : rs2_data;

    alu alu_inst (
        .a            (op_a),
        .b            (op_b),
        .alu_op       (alu_op),
        .cmp_op       (cmp_op),
        .result       (result),
        .branch_taken (branch_taken)
    );

    pc_unit #(
        .RESET_PC (RESET_PC)
    ) pc_unit_inst (
        .clk          (clk),
        .reset        (reset),
        .pc_sel       (pc_sel),
        .branch_taken (branch_taken),
        .is_branch    (is_branch),
        .imm          (imm),
        .jalr_target  (result),
        .pc           (pc),
        .pc_plus4     (pc_plus4)
    );

    always_comb begin
        case (wb_sel)
            WB_LOAD: wb_data = dmem_rdata;
            WB_PC4:  wb_data = pc_plus4;
            WB_IMM:  wb_data = imm;
            default: wb_data = result;
        endcase
    end

    assign imem_addr  = pc;
    assign dmem_addr  = result;
    assign dmem_wdata = rs2_data;
    assign dmem_we    = mem_we && !reset;

endmodule

// ==== hw/alu.sv ====
// Arithmetic and logic unit plus branch comparator for rv32_core
`timescale 1ns/1ps

module alu (
    input  rv_pkg::word_t   a,
    input  rv_pkg::word_t   b,
    input  rv_pkg::alu_op_e alu_op,
    input  rv_pkg::cmp_op_e cmp_op,
    output rv_pkg::word_t   result,
    output logic            branch_taken
);
    import rv_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (alu_op)
            ALU_ADD:  result = a + b;
            ALU_SUB:  result = a - b;
            ALU_SLL:  result = a << shamt;
            ALU_SLT:  result = {31'b0, lt_signed};
            ALU_SLTU: result = {31'b0, lt_unsigned};
            ALU_XOR:  result = a ^ b;
            ALU_SRL:  result = a >> shamt;
            ALU_SRA:  result = $signed(a) >>> shamt;
            ALU_OR:   result = a | b;
            ALU_AND:  result = a & b;
            default:  result = '0;
        endcase
    end

    // Branch decision, independent of result
    always_comb begin
        case (cmp_op)
            CMP_EQ:  branch_taken = (a == b);
            CMP_NE:  branch_taken = (a != b);
            CMP_LT:  branch_taken = lt_signed;
            CMP_GE:  branch_taken = !lt_signed;
            CMP_LTU: branch_taken = lt_unsigned;
            CMP_GEU: branch_taken = !lt_unsigned;
            default: branch_taken = 1'b0;
        endcase
    end

endmodule

// ==== hw/regfile.sv ====
// Integer register file with two combinational reads and one clocked write port
`timescale 1ns/1ps

module regfile (
    input  logic             clk,
    input  logic             reset,
    input  logic             we,
    input  rv_pkg::reg_idx_t rs1,
    input  rv_pkg::reg_idx_t rs2,
    input  rv_pkg::reg_idx_t rd,
    input  rv_pkg::word_t    wdata,
    output rv_pkg::word_t    rs1_data,
    output rv_pkg::word_t    rs2_data
);
    import rv_pkg::*;

    word_t regs [1:31]; // x0 has no storage

    assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wdata;
        end
    end

endmodule

// ==== hw/imm_gen.sv ====
// Immediate generator for the I, S, B, U and J formats, used by rv32_core
`timescale 1ns/1ps

module imm_gen (
    input  rv_pkg::word_t instr,
    output rv_pkg::word_t imm
);
    import rv_pkg::*;

    word_t imm_i;
    word_t imm_s;
    word_t imm_b;
    word_t imm_u;
    word_t imm_j;

    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    always_comb begin
        case (opcode_e'(instr[6:0]))
            OP_IMM, LOAD, JALR: imm = imm_i;
            STORE:              imm = imm_s;
            BRANCH:             imm = imm_b;
            LUI, AUIPC:         imm = imm_u;
            JAL:                imm = imm_j;
            default:            imm = '0; // R-type and unknown
        endcase
    end

endmodule

// ==== hw/control_decoder.sv ====
// Combinational instruction decoder producing datapath controls for rv32_core
`timescale 1ns/1ps

module control_decoder (
    input  rv_pkg::word_t    instr,
    output rv_pkg::alu_op_e  alu_op,
    output rv_pkg::cmp_op_e  cmp_op,
    output logic             alu_src_imm,
    output logic             alu_src_pc,
    output rv_pkg::wb_sel_e  wb_sel,
    output rv_pkg::pc_sel_e  pc_sel,
    output logic             is_branch,
    output logic             reg_we,
    output logic             mem_we,
    output rv_pkg::reg_idx_t rs1,
    output rv_pkg::reg_idx_t rs2,
    output rv_pkg::reg_idx_t rd
);
    import rv_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       funct7_b5;
    logic       word_access;

    // ALU operation shared by OP and OP_IMM
    function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
        alu_op_e op;
        case (f3)
            3'b000:  op = alt ? ALU_SUB : ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = alt ? ALU_SRA : ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    assign opcode      = opcode_e'(instr[6:0]);
    assign funct3      = instr[14:12];
    assign funct7_b5   = instr[30];
    assign word_access = (funct3 == 3'b010); // Only LW and SW are kept

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    assign rd  = instr[11:7];

    always_comb begin
        alu_op      = ALU_ADD;
        cmp_op      = CMP_EQ;
        alu_src_imm = 1'b0;
        alu_src_pc  = 1'b0;
        wb_sel      = WB_ALU;
        pc_sel      = PC_SEQ;
        is_branch   = 1'b0;
        reg_we      = 1'b0;
        mem_we      = 1'b0;

        case (opcode)
            OP: begin
                alu_op = alu_from_funct(funct3, funct7_b5);
                reg_we = 1'b1;
            end
            OP_IMM: begin
                // Only SRAI uses funct7 bit 5, ADDI has no subtract form
                alu_op      = alu_from_funct(funct3, funct7_b5 && funct3 == 3'b101);
                alu_src_imm = 1'b1;
                reg_we      = 1'b1;
            end
            LOAD: begin
                alu_src_imm = 1'b1;
                wb_sel      = WB_LOAD;
                reg_we      = word_access;
            end
            STORE: begin
                alu_src_imm = 1'b1;
                mem_we      = word_access;
            end
            BRANCH: begin
                cmp_op    = cmp_op_e'(funct3); // 010 and 011 never taken in the alu
                is_branch = 1'b1;
                pc_sel    = PC_JAL_BR;
            end
            JAL: begin
                wb_sel = WB_PC4;
                pc_sel = PC_JAL_BR;
                reg_we = 1'b1;
            end
            JALR: begin
                alu_src_imm = 1'b1; // rs1 + imm
                wb_sel      = WB_PC4;
                pc_sel      = PC_JALR;
                reg_we      = 1'b1;
            end
            LUI: begin
                wb_sel = WB_IMM;
                reg_we = 1'b1;
            end
            AUIPC: begin
                alu_src_pc  = 1'b1;
                alu_src_imm = 1'b1;
                reg_we      = 1'b1;
            end
            default: ; // Unknown opcode runs as a no-op
        endcase
    end

endmodule

// ==== hw/pc_unit.sv ====
// Program counter with next-PC selection, instantiated once inside rv32_core
`timescale 1ns/1ps

module pc_unit #(
    parameter rv_pkg::word_t RESET_PC = rv_pkg::DEFAULT_RESET_PC
) (
    input  logic            clk,
    input  logic            reset,
    input  rv_pkg::pc_sel_e pc_sel,
    input  logic            branch_taken,
    input  logic            is_branch,
    input  rv_pkg::word_t   imm,
    input  rv_pkg::word_t   jalr_target,
    output rv_pkg::word_t   pc,
    output rv_pkg::word_t   pc_plus4
);
    import rv_pkg::*;

    word_t pc_target;
    word_t pc_next;

    assign pc_plus4  = pc + 32'd4;
    assign pc_target = pc + imm; // JAL and branch target

    always_comb begin
        case (pc_sel)
            PC_JAL_BR: begin
                // Untaken branch falls through
                if (is_branch && !branch_taken) begin
                    pc_next = pc_plus4;
                end else begin
                    pc_next = pc_target;
                end
            end
            PC_JALR: pc_next = {jalr_target[31:1], 1'b0};
            default: pc_next = pc_plus4;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= RESET_PC;
        end else begin
            pc <= pc_next;
        end
    end

    pc_word_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
        else $error("pc not word aligned: %h", pc);

endmodule

// ==== hw/rv_pkg.sv ====
// Shared types and encodings for the RV32I core, imported by every RTL unit and the testbench
package rv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_SLT  = 4'd3,
        ALU_SLTU = 4'd4,
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9
    } alu_op_e;

    // Same codes as the branch funct3 field
    typedef enum logic [2:0] {
        CMP_EQ  = 3'b000,
        CMP_NE  = 3'b001,
        CMP_LT  = 3'b100,
        CMP_GE  = 3'b101,
        CMP_LTU = 3'b110,
        CMP_GEU = 3'b111
    } cmp_op_e;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_LOAD = 2'd1,
        WB_PC4  = 2'd2, // Link value for JAL and JALR
        WB_IMM  = 2'd3  // LUI
    } wb_sel_e;

    typedef enum logic [1:0] {
        PC_SEQ    = 2'd0,
        PC_JAL_BR = 2'd1,
        PC_JALR   = 2'd2
    } pc_sel_e;

    localparam word_t DEFAULT_RESET_PC = 32'h0000_0000;

endpackage
